// ==== irq_trace.f ====
source/trace_pkg.sv
source/trace_encoder.sv
source/trace_fifo.sv
source/irq_trace.sv
sim/irq_trace_assertions.sv
sim/irq_trace_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := irq_trace_tb
FILELIST  := irq_trace.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Testbench failed
PASS_MSG  := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/irq_trace_tb.sv ====
// testbench for irq_trace that applies an event table and checks the encoded bytes on the link
`default_nettype none
`timescale 1ns/1ps

module irq_trace_tb
  import trace_pkg::*;
();

  typedef struct {
    string       name;
    prio_t       lvl;
    logic        tc;
    logic        csr_en;
    logic [11:0] addr;
    logic [7:0]  csr_byte;
    timer_t      stamp;
    logic        hold;
    logic        drop;
    logic        ovf;
    int          cnt;
    logic [63:0] bytes;
  } row_t;

  logic                  clk_i;
  logic                  reset_i;
  logic [HartIdBits-1:0] hart_id;
  timer_t                timer;
  prio_t                 level;
  logic                  tail_chain;
  csr_req_t              csr;
  logic                  credit_return = 1'b0;
  link_byte_t            link_out;
  logic                  overflow;

  row_t       rows[$];
  logic [7:0] exp_q[$];
  logic [7:0] got_q[$];
  integer     seed = 97230;
  int         owed = 0;
  int         delay = 0;
  int         errors = 0;
  bit         hold_credits = 1'b0;
  bit         aborted = 1'b0;

  irq_trace UUT (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .hart_id       (hart_id),
    .timer         (timer),
    .level         (level),
    .tail_chain    (tail_chain),
    .csr           (csr),
    .credit_return (credit_return),
    .link_out      (link_out),
    .overflow      (overflow)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // sink gives one credit back per byte after a short random delay
  always @(posedge clk_i) begin
    if (reset_i) begin
      credit_return <= 1'b0;
      owed = 0;
      delay = 0;
    end else begin
      credit_return <= 1'b0;
      if (link_out.valid) begin
        got_q.push_back(link_out.data);
        owed++;
      end
      if (!hold_credits && owed > 0) begin
        if (delay == 0) begin
          credit_return <= 1'b1;
          owed--;
          delay = $unsigned($random(seed)) % 4;
        end else begin
          delay--;
        end
      end
    end
  end

  task automatic add_row(input string name, input prio_t lvl, input logic tc, input logic csr_en,
                         input logic [11:0] addr, input logic [7:0] csr_byte,
                         input timer_t stamp, input logic hold, input logic drop,
                         input logic ovf, input int cnt, input logic [63:0] bytes);
    row_t r;
    r = '{name, lvl, tc, csr_en, addr, csr_byte, stamp, hold, drop, ovf, cnt, bytes};
    rows.push_back(r);
  endtask

  task automatic check_value(input string what, input int expected, input int actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %0h actual %0h", what, expected, actual);
      errors++;
    end
  endtask

  task automatic wait_bytes(input string name);
    int cycles;
    cycles = 0;
    while (!aborted && got_q.size() < exp_q.size()) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 300) begin
        $display("bytes for %s never arrived", name);
        aborted = 1'b1;
      end
    end
  endtask

  task automatic wait_credits(input string name);
    int cycles;
    cycles = 0;
    while (!aborted && owed != 0) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 100) begin
        $display("credits before %s were never returned", name);
        aborted = 1'b1;
      end
    end
  endtask

  task automatic apply_row(input row_t r);
    @(posedge clk_i);
    level      <= r.lvl;
    tail_chain <= r.tc;
    timer      <= r.stamp;
    csr        <= '{enable: r.csr_en, addr: r.addr, wdata: {24'h5A5A5A, r.csr_byte}};
    // back to quiet inputs at the same level
    @(posedge clk_i);
    tail_chain <= 1'b0;
    csr        <= '0;
  endtask

  initial begin
    row_t r;
    int   start_errors;
    int   stalled;
    reset_i    = 1'b1;
    hart_id    = 4'hA;
    timer      = '0;
    level      = '0;
    tail_chain = 1'b0;
    csr        = '0;

    add_row("push_0_to_3", 3, 0, 0, TraceByteCsrAddr, 8'h00, 32'h12003456, 0, 0, 0,
            5, 64'hA3_12_03_34_56);
    add_row("csr_nonzero", 3, 0, 1, TraceByteCsrAddr, 8'h5A, 32'h0, 0, 0, 0, 1, 64'h5A);
    add_row("csr_zero", 3, 0, 1, TraceByteCsrAddr, 8'h00, 32'h0, 0, 0, 0, 1, 64'h04);
    add_row("csr_other_addr", 3, 0, 1, 12'h8C1, 8'h77, 32'h0, 0, 0, 0, 0, 64'h0);
    add_row("pop_3_to_0", 0, 0, 0, TraceByteCsrAddr, 8'h00, 32'h00AB00CD, 0, 0, 0,
            6, 64'h01_AB_02_CD_01_00);
    add_row("push_0_to_2", 2, 0, 0, TraceByteCsrAddr, 8'h00, 32'h01020304, 0, 0, 0,
            5, 64'hA2_01_02_03_04);
    add_row("tail_chain_csr", 2, 1, 1, TraceByteCsrAddr, 8'h00, 32'h11223344, 0, 0, 0,
            8, 64'h06_00_A2_11_22_33_44_06);
    add_row("credit_stall", 0, 0, 0, TraceByteCsrAddr, 8'h00, 32'h0A0B0C0D, 1, 0, 0,
            6, 64'h0A_0B_0C_0D_01_00);
    add_row("credit_release", 0, 0, 1, 12'h8C1, 8'h77, 32'h0, 0, 0, 0, 0, 64'h0);
    // fill the FIFO with credits held until 29 bytes are stored
    add_row("fill_push_a", 5, 0, 0, TraceByteCsrAddr, 8'h00, 32'h21222324, 1, 0, 0,
            5, 64'hA5_21_22_23_24);
    add_row("fill_pop_a", 0, 0, 0, TraceByteCsrAddr, 8'h00, 32'h31323334, 1, 0, 0,
            6, 64'h31_32_33_34_06_00);
    add_row("fill_push_b", 5, 0, 0, TraceByteCsrAddr, 8'h00, 32'h41424344, 1, 0, 0,
            5, 64'hA5_41_42_43_44);
    add_row("fill_pop_b", 0, 0, 0, TraceByteCsrAddr, 8'h00, 32'h51525354, 1, 0, 0,
            6, 64'h51_52_53_54_06_00);
    add_row("fill_push_c", 5, 0, 0, TraceByteCsrAddr, 8'h00, 32'h61626364, 1, 0, 0,
            5, 64'hA5_61_62_63_64);
    add_row("fill_pop_c", 0, 0, 0, TraceByteCsrAddr, 8'h00, 32'h71727374, 1, 0, 0,
            6, 64'h71_72_73_74_06_00);
    add_row("drop_push", 5, 0, 0, TraceByteCsrAddr, 8'h00, 32'h81828384, 1, 1, 1,
            5, 64'hA5_81_82_83_84);
    add_row("drop_pop", 0, 0, 0, TraceByteCsrAddr, 8'h00, 32'h91929394, 1, 1, 1,
            6, 64'h91_92_93_94_06_00);
    add_row("drain_after_drop", 0, 0, 1, TraceByteCsrAddr, 8'hE1, 32'h0, 0, 0, 1,
            1, 64'hE1);

    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;

    for (int t = 0; t < rows.size(); t++) begin
      r = rows[t];
      @(negedge clk_i);
      if (r.hold && !hold_credits) begin
        wait_credits(r.name);
      end
      if (aborted) break;
      hold_credits = r.hold;
      start_errors = errors;
      apply_row(r);
      if (!r.drop) begin
        for (int i = 0; i < r.cnt; i++) begin
          exp_q.push_back(r.bytes[8*(r.cnt-1-i) +: 8]);
        end
      end
      if (r.hold) begin
        // link must stop once the credits are spent
        repeat (10) @(negedge clk_i);
        stalled = (exp_q.size() < LinkCredits) ? exp_q.size() : LinkCredits;
        check_value({r.name, " stalled bytes"}, stalled, got_q.size());
      end else begin
        wait_bytes(r.name);
        if (aborted) break;
        repeat (6) @(negedge clk_i);
        check_value({r.name, " byte count"}, exp_q.size(), got_q.size());
        while (exp_q.size() > 0 && got_q.size() > 0) begin
          check_value(r.name, exp_q.pop_front(), got_q.pop_front());
        end
        exp_q.delete();
        got_q.delete();
      end
      check_value({r.name, " overflow"}, r.ovf, overflow);
      $display("test %-18s %0d mismatches", r.name, errors - start_errors);
    end

    $display("%0d tests, %0d errors", rows.size(), errors);
    if (errors == 0 && !aborted) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/irq_trace_assertions.sv ====
// link and FIFO property checks attached to every trace_fifo instance through bind
`default_nettype none
`timescale 1ns/1ps

module irq_trace_assertions
  import trace_pkg::*;
(
  input logic    clk_i,
  input logic    reset_i,
  input logic    valid,
  input logic    credit_return,
  input credit_t credits,
  input logic    overflow
);

  // bytes on the link not yet paid back by the sink
  credit_t in_flight;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + credit_t'(valid) - credit_t'(credit_return);
    end
  end

  // nothing leaves once every credit is out on the link
  no_byte_without_credit: assert property (
    @(posedge clk_i) disable iff (reset_i)
      !(valid && (in_flight >= credit_t'(LinkCredits)))
  ) else $error("link byte valid while credit count is zero");

  credits_bounded: assert property (
    @(posedge clk_i) disable iff (reset_i) credits <= credit_t'(LinkCredits)
  ) else $error("credit count above the link limit");

  // sticky flag
  overflow_sticky: assert property (
    @(posedge clk_i) disable iff (reset_i) (!$past(reset_i) && $past(overflow)) |-> overflow
  ) else $error("overflow fell without reset");

endmodule

bind trace_fifo irq_trace_assertions u_assertions (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .valid         (link_out.valid),
  .credit_return (credit_return),
  .credits       (credits),
  .overflow      (overflow)
);

`default_nettype wire

// ==== source/irq_trace.sv ====
// top of the interrupt trace unit joining the encoder and byte FIFO onto the credited link
`default_nettype none
`timescale 1ns/1ps

module irq_trace
  import trace_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [HartIdBits-1:0] hart_id,
  input  timer_t                timer,
  input  prio_t                 level,
  input  logic                  tail_chain,
  input  csr_req_t              csr,
  input  logic                  credit_return,
  output link_byte_t            link_out,
  output logic                  overflow
);

  trace_entry_t entry;

  trace_encoder u_encoder (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .hart_id    (hart_id),
    .timer      (timer),
    .level      (level),
    .tail_chain (tail_chain),
    .csr        (csr),
    .entry      (entry)
  );

  // count of zero means idle
  trace_fifo u_fifo (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .entry         (entry),
    .credit_return (credit_return),
    .link_out      (link_out),
    .overflow      (overflow)
  );

endmodule

`default_nettype wire

// ==== source/trace_fifo.sv ====
// byte FIFO taking whole trace entries of up to eight bytes and draining one byte per credit
`default_nettype none
`timescale 1ns/1ps

module trace_fifo
  import trace_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  trace_entry_t entry,
  input  logic         credit_return,
  output link_byte_t   link_out,
  output logic         overflow
);

  logic [7:0]  mem [FifoDepth];
  fifo_ptr_t   wr_ptr;
  fifo_ptr_t   rd_ptr;
  fifo_level_t fill;
  fifo_level_t free_space;
  credit_t     credits;
  logic        fits;
  logic        push;
  logic        pop;

  assign free_space = fifo_level_t'(FifoDepth) - fill;
  assign fits       = fifo_level_t'(entry.count) <= free_space;
  // entries are all or nothing
  assign push       = (entry.count != '0) && fits;
  // a byte goes out only against a credit
  assign pop        = (fill != '0) && (credits != '0);

  assign link_out = '{valid: pop, data: mem[rd_ptr]};

  // byte k lands at wr_ptr + k and wraps with the pointer width
  always_ff @(posedge clk_i) begin
    if (push) begin
      for (int k = 0; k < EntryBytes; k++) begin
        if (entry_count_t'(k) < entry.count) begin
          mem[wr_ptr + fifo_ptr_t'(k)] <= entry.data[k];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + fifo_ptr_t'(entry.count);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + fifo_ptr_t'(1);
      end
      fill <= fill + (push ? fifo_level_t'(entry.count) : fifo_level_t'(0))
              - fifo_level_t'(pop);
    end
  end

  // sink returns at most what it took
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits <= credit_t'(LinkCredits);
    end else begin
      credits <= credits - credit_t'(pop) + credit_t'(credit_return);
    end
  end

  // sticky until reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      overflow <= 1'b0;
    end else if ((entry.count != '0) && !fits) begin
      overflow <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/trace_encoder.sv ====
// builds reverse COBS frame bytes per priority level from level changes, tail chains and CSR writes
`default_nettype none
`timescale 1ns/1ps

module trace_encoder
  import trace_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [HartIdBits-1:0] hart_id,
  input  timer_t                timer,
  input  prio_t                 level,
  input  logic                  tail_chain,
  input  csr_req_t              csr,
  output trace_entry_t          entry
);

  prio_t        old_level;
  // distance to the last replaced zero, one per level
  logic [7:0]   counter [PrioNum];
  logic [7:0]   run_next;
  logic [7:0]   header;
  logic         csr_hit;
  entry_data_t  data_next;
  entry_count_t count_next;
  entry_data_t  data_q;
  entry_count_t count_q;

  assign header  = {hart_id, level};
  assign csr_hit = csr.enable && (csr.addr == TraceByteCsrAddr);

  // a zero never goes out inside a frame, the running count takes its place
  function automatic void enqueue(input logic [7:0] val, inout logic [7:0] run,
                                  inout entry_data_t data, inout entry_count_t idx);
    if (val == 8'h00) begin
      data[idx[2:0]] = run;
      run = 8'd1;
    end else begin
      data[idx[2:0]] = val;
      run = run + 8'd1;
    end
    idx = idx + 4'd1;
  endfunction

  // most significant byte first
  function automatic void enqueue_timer(input timer_t stamp, inout logic [7:0] run,
                                        inout entry_data_t data, inout entry_count_t idx);
    for (int i = 0; i < TimerBytes; i++) begin
      enqueue(stamp[8*(TimerBytes-1-i) +: 8], run, data, idx);
    end
  endfunction

  function automatic void open_frame(input logic [7:0] head, input timer_t stamp,
                                     inout logic [7:0] run, inout entry_data_t data,
                                     inout entry_count_t idx);
    run = 8'd1;
    enqueue(head, run, data, idx);
    enqueue_timer(stamp, run, data, idx);
  endfunction

  // final count then the sentinel
  function automatic void close_frame(input logic [7:0] run, inout entry_data_t data,
                                      inout entry_count_t idx);
    data[idx[2:0]] = run;
    data[idx[2:0] + 3'd1] = 8'h00;
    idx = idx + 4'd2;
  endfunction

  always_comb begin
    data_next  = '0;
    count_next = '0;
    run_next   = counter[level];
    if (level > old_level) begin
      // nested interrupt taken
      open_frame(header, timer, run_next, data_next, count_next);
    end else if (tail_chain) begin
      close_frame(counter[old_level], data_next, count_next);
      open_frame(header, timer, run_next, data_next, count_next);
    end else if (level < old_level) begin
      // resumed level gets the timestamp on return
      enqueue_timer(timer, run_next, data_next, count_next);
      close_frame(counter[old_level], data_next, count_next);
    end
    if (csr_hit) begin
      enqueue(csr.wdata[7:0], run_next, data_next, count_next);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      old_level <= level;
      counter   <= '{default: 8'd1};
      count_q   <= '0;
    end else begin
      old_level      <= level;
      counter[level] <= run_next;
      count_q        <= count_next;
    end
  end

  always_ff @(posedge clk_i) begin
    data_q <= data_next;
  end

  assign entry = '{data: data_q, count: count_q};

endmodule

`default_nettype wire

// ==== source/trace_pkg.sv ====
// shared widths, constants and bundle types for the interrupt trace unit; import into each block
`default_nettype none

package trace_pkg;

  // priority levels
  localparam int PrioBits = 4;
  localparam int PrioNum  = 16;
  typedef logic [PrioBits-1:0] prio_t;

  // upper nibble of the frame header
  localparam int HartIdBits = 4;

  // monotonic timer
  localparam int TimerBytes = 4;
  typedef logic [TimerBytes*8-1:0] timer_t;

  // close 2 + header 1 + timer 4 + csr byte 1
  localparam int EntryBytes = 8;
  typedef logic [3:0] entry_count_t;
  typedef logic [EntryBytes-1:0][7:0] entry_data_t;

  // byte 0 leaves first, count of zero writes nothing
  typedef struct packed {
    entry_data_t  data;
    entry_count_t count;
  } trace_entry_t;

  typedef struct packed {
    logic        enable;
    logic [11:0] addr;
    logic [31:0] wdata;
  } csr_req_t;

  localparam logic [11:0] TraceByteCsrAddr = 12'h8C0;

  // byte FIFO
  localparam int FifoDepth = 32;
  typedef logic [4:0] fifo_ptr_t;
  typedef logic [5:0] fifo_level_t;

  // output link flow control
  localparam int LinkCredits = 4;
  localparam int CreditBits  = $clog2(LinkCredits + 1);
  typedef logic [CreditBits-1:0] credit_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } link_byte_t;

endpackage

`default_nettype wire
